//--- rob_pkg.sv
// Sizes, slot types and block interface structs for the reorder buffer, imported by every ROB module
package rob_pkg;

    // ====================
    // Sizes
    // ====================

    // The ring has this many slots and the count must be a power of two
    localparam int ROB_ENTRIES = 16;

    // Width of a slot index derived from the slot count
    localparam int ROB_IDX_BITS = $clog2(ROB_ENTRIES);

    // Width of one response data word
    localparam int ROB_DATA_BITS = 32;

    // Width of the meta tag stored at allocation time
    localparam int ROB_META_BITS = 8;

    // Slots that must stay free for not_full to be high
    localparam int ROB_MIN_FREE = 1;

    // Read latency of the valid-bit RAM in cycles
    // The scan pipeline in the ready tracker is built to match this depth
    localparam int ROB_VALID_RD_LAT = 2;

    // ====================
    // Types
    // ====================

    // Slot index that is also the handle returned to the requester
    typedef logic [ROB_IDX_BITS-1:0] rob_idx_t;

    // Response payload
    typedef logic [ROB_DATA_BITS-1:0] rob_data_t;

    // Meta tag kept alongside each slot
    typedef logic [ROB_META_BITS-1:0] rob_meta_t;

    // Response write from the memory side
    // The index is the handle that was returned when the slot was allocated
    typedef struct packed {
        rob_idx_t  idx;
        rob_data_t data;
    } rob_wr_t;

    // Ordered result handed to the requester
    // Data and meta always belong to the same slot
    typedef struct packed {
        rob_data_t data;
        rob_meta_t meta;
    } rob_out_t;

endpackage

//--- rob_ram.sv
// Simple dual-port block RAM with a registered read and extra output stages, used for ROB payloads
`timescale 1ns/1ns

module rob_ram
#(
    parameter int DEPTH      = rob_pkg::ROB_ENTRIES,
    parameter int WIDTH      = rob_pkg::ROB_DATA_BITS,
    parameter int OUT_STAGES = 1
)
(
    input  logic                    clk,

    // Write port
    input  rob_pkg::rob_idx_t       waddr,
    input  logic                    wen,
    input  logic [WIDTH-1:0]        wdata,

    // Read port with data 1 + OUT_STAGES cycles after raddr
    input  rob_pkg::rob_idx_t       raddr,
    output logic [WIDTH-1:0]        rdata
);

    // Storage array
    logic [WIDTH-1:0] mem [0:DEPTH-1];

    // Read pipeline
    // Stage 0 is the registered read and the rest are output registers
    logic [WIDTH-1:0] rd_pipe [0:OUT_STAGES];

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end

        // A read of the slot being written returns the old contents
        rd_pipe[0] <= mem[raddr];

        // Shift through the output stages
        for (int i = 1; i <= OUT_STAGES; i++)
        begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    // Last stage drives the port
    assign rdata = rd_pipe[OUT_STAGES];

endmodule

//--- rob_ram_init.sv
// One-bit valid RAM that zeroes itself after reset and flags rdy once every slot is cleared
`timescale 1ns/1ns

module rob_ram_init
(
    input  logic              clk,
    input  logic              reset,

    // High once the clear pass has finished
    output logic              rdy,

    // Read port with ROB_VALID_RD_LAT cycles of latency
    input  rob_pkg::rob_idx_t raddr,
    output logic              rdata,

    // External write port that is only honored after the clear
    input  rob_pkg::rob_idx_t waddr,
    input  logic              wen,
    input  logic              wdata
);

    import rob_pkg::*;

    // Clear sequencer states
    typedef enum logic {
        INIT_CLEAR,
        INIT_READY
    } init_state_t;

    init_state_t state;
    rob_idx_t    clr_idx;

    logic        mem     [0:ROB_ENTRIES-1];
    logic        rd_pipe [0:ROB_VALID_RD_LAT-1];

    // ====================
    // Clear sequencer
    // ====================

    // Walk every address once after reset and then hand over the write port
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= INIT_CLEAR;
            clr_idx <= '0;
        end
        else if (state == INIT_CLEAR)
        begin
            clr_idx <= clr_idx + 1'b1;
            // The last address is written in this same cycle
            if (clr_idx == rob_idx_t'(ROB_ENTRIES - 1))
            begin
                state <= INIT_READY;
            end
        end
    end

    assign rdy = (state == INIT_READY);

    // ====================
    // Storage
    // ====================

    always_ff @(posedge clk)
    begin
        // During the clear the sequencer owns the write port
        if (state == INIT_CLEAR)
        begin
            mem[clr_idx] <= 1'b0;
        end
        else if (wen)
        begin
            mem[waddr] <= wdata;
        end

        // Registered read followed by the output stages
        rd_pipe[0] <= mem[raddr];
        for (int i = 1; i < ROB_VALID_RD_LAT; i++)
        begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign rdata = rd_pipe[ROB_VALID_RD_LAT-1];

    // A response write during the clear would be dropped
    a_no_wr_in_clear: assert property (@(posedge clk) disable iff (reset) wen |-> rdy)
        else $error("rob_ram_init: write during the clear");

endmodule

//--- rob_ready_scan.sv
// Tracks response arrival per slot and counts how many oldest slots are ready to dequeue
`timescale 1ns/1ns

module rob_ready_scan
(
    input  logic              clk,
    input  logic              reset,

    // Response write strobe and its slot
    input  logic              wr_en,
    input  rob_pkg::rob_idx_t wr_idx,

    // Ring state from pointer control
    input  rob_pkg::rob_idx_t oldest,
    input  logic              valid_tag,
    input  logic              deq_en,

    // The oldest slot has its data
    output logic              not_empty,

    // Valid-bit RAM has finished its clear
    output logic              init_done
);

    import rob_pkg::*;

    // One entry of the scan pipeline
    // idx is the slot under test, tgt the tag that means arrived on this trip,
    // and ignore marks a speculative test that was cancelled by a rewind
    typedef struct packed {
        rob_idx_t idx;
        logic     tgt;
        logic     ignore;
    } scan_stage_t;

    // Small saturating count of ready oldest slots
    typedef logic [2:0] ready_cnt_t;

    scan_stage_t scan [0:ROB_VALID_RD_LAT];
    ready_cnt_t  num_ready;
    logic        wr_tag;
    logic        rd_valid;
    logic        hit;

    // ====================
    // Valid bits
    // ====================

    // The RAM has only one write port, so the meaning of a stored bit flips
    // on every trip around the ring instead of clearing bits on dequeue.
    // Slots at or above oldest belong to the current trip.
    // Slots below oldest have already wrapped and take the next trip's tag
    assign wr_tag = (wr_idx >= oldest) ? valid_tag : ~valid_tag;

    rob_ram_init u_valid_ram
    (
        .clk   (clk),
        .reset (reset),
        .rdy   (init_done),
        .raddr (scan[0].idx),
        .rdata (rd_valid),
        .waddr (wr_idx),
        .wen   (wr_en),
        .wdata (wr_tag)
    );

    // ====================
    // Speculative scan
    // ====================

    // The read result lines up with the last pipeline stage.
    // A hit needs the right tag, a live test and room in the counter
    assign hit = (rd_valid == scan[ROB_VALID_RD_LAT].tgt) &&
                 !scan[ROB_VALID_RD_LAT].ignore &&
                 (num_ready != ready_cnt_t'(7));

    always_ff @(posedge clk)
    begin
        if (reset || !init_done)
        begin
            // Start at slot 0 looking for the first-trip tag.
            // Only stage 0 holds a real test until the pipeline fills
            for (int i = 0; i <= ROB_VALID_RD_LAT; i++)
            begin
                scan[i] <= '{idx: '0, tgt: 1'b1, ignore: 1'b1};
            end
            scan[0].ignore <= 1'b0;
        end
        else
        begin
            // Move every test one stage along
            for (int i = 0; i < ROB_VALID_RD_LAT; i++)
            begin
                scan[i+1] <= scan[i];
            end

            if (!hit && !scan[ROB_VALID_RD_LAT].ignore)
            begin
                // Miss on a live test, so retry the same slot and tag
                scan[0].idx <= scan[ROB_VALID_RD_LAT].idx;
                scan[0].tgt <= scan[ROB_VALID_RD_LAT].tgt;

                // Younger tests assumed this slot was ready and are dropped
                for (int i = 1; i <= ROB_VALID_RD_LAT; i++)
                begin
                    scan[i].ignore <= 1'b1;
                end
            end
            else
            begin
                // Guess that the slot now entering will hit and move on
                scan[0].idx <= scan[0].idx + 1'b1;

                // Crossing the top of the ring flips the target like valid_tag
                if (scan[0].idx == rob_idx_t'(ROB_ENTRIES - 1))
                begin
                    scan[0].tgt <= ~scan[0].tgt;
                end
            end
        end
    end

    // ====================
    // Ready count
    // ====================

    // Each hit adds one ready slot and each dequeue removes one.
    // The count only has to stay ahead of the consumer
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            num_ready <= '0;
        end
        else
        begin
            num_ready <= num_ready - ready_cnt_t'(deq_en) + ready_cnt_t'(hit);
        end
    end

    assign not_empty = (num_ready != '0);

endmodule

//--- rob_ptr_ctrl.sv
// Ring pointer control for the ROB with full and empty checks and the dequeue output timing
`timescale 1ns/1ns

module rob_ptr_ctrl
(
    input  logic              clk,
    input  logic              reset,

    // Requester side strobes
    input  logic              alloc_en,
    input  logic              deq_en,

    // Status from the ready tracker
    input  logic              init_done,
    input  logic              not_empty,

    // Ring state
    output rob_pkg::rob_idx_t newest,
    output rob_pkg::rob_idx_t oldest,
    output logic              valid_tag,

    // Flags toward the requester
    output logic              not_full,
    output logic              out_valid
);

    import rob_pkg::*;

    // One bit wider than an index so the slot count itself fits
    typedef logic [ROB_IDX_BITS:0] slot_cnt_t;

    rob_idx_t   used;
    logic [1:0] deq_pipe;

    // ====================
    // Pointers
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            newest    <= '0;
            oldest    <= '0;
            // The valid RAM clears to 0, so the first trip looks for 1
            valid_tag <= 1'b1;
        end
        else
        begin
            if (alloc_en)
            begin
                newest <= newest + 1'b1;
            end

            if (deq_en)
            begin
                oldest <= oldest + 1'b1;
                // Leaving the top slot starts a new trip
                if (oldest == rob_idx_t'(ROB_ENTRIES - 1))
                begin
                    valid_tag <= ~valid_tag;
                end
            end
        end
    end

    // The outstanding count is unambiguous because the ring never fills completely
    assign used = newest - oldest;

    // Hold off allocation until the valid bits are clean
    assign not_full = init_done &&
                      ((slot_cnt_t'(used) + slot_cnt_t'(ROB_MIN_FREE)) <
                       slot_cnt_t'(ROB_ENTRIES));

    // ====================
    // Output timing
    // ====================

    // Both payload RAMs take two cycles from the oldest address to their output
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            deq_pipe <= '0;
        end
        else
        begin
            deq_pipe <= {deq_pipe[0], deq_en};
        end
    end

    assign out_valid = deq_pipe[1];

    // Allocation past the free-slot limit would overrun unread slots
    a_no_alloc_full: assert property (@(posedge clk) disable iff (reset)
        alloc_en |-> not_full)
        else $error("rob_ptr_ctrl: allocation while full");

    // A dequeue must wait until the tracker has seen the oldest response
    a_no_deq_empty: assert property (@(posedge clk) disable iff (reset)
        deq_en |-> not_empty)
        else $error("rob_ptr_ctrl: dequeue while empty");

    // Pointer wrap and the trip tag rely on a power-of-two ring
    a_pow2_depth: assert property (@(posedge clk)
        ROB_ENTRIES == (1 << ROB_IDX_BITS))
        else $error("rob_ptr_ctrl: ROB_ENTRIES is not a power of two");

endmodule

//--- rob_top.sv
// Reorder buffer top level that returns out-of-order read responses in allocation order
`timescale 1ns/1ns

module rob_top
(
    input  logic               clk,
    input  logic               reset,

    // Allocation of one slot per strobe
    input  logic               alloc_en,
    input  rob_pkg::rob_meta_t alloc_meta,
    output rob_pkg::rob_idx_t  alloc_idx,
    output logic               not_full,

    // Response writes that are always accepted
    input  logic               wr_en,
    input  rob_pkg::rob_wr_t   wr,

    // Ordered output with data two cycles after deq_en
    input  logic               deq_en,
    output logic               not_empty,
    output logic               out_valid,
    output rob_pkg::rob_out_t  out
);

    import rob_pkg::*;

    rob_idx_t  newest;
    rob_idx_t  oldest;
    logic      valid_tag;
    logic      init_done;
    rob_data_t rd_data;
    rob_meta_t rd_meta;

    // ====================
    // Control
    // ====================

    // The handle for a new request is simply the newest pointer
    assign alloc_idx = newest;

    rob_ptr_ctrl u_ptr_ctrl
    (
        .clk       (clk),
        .reset     (reset),
        .alloc_en  (alloc_en),
        .deq_en    (deq_en),
        .init_done (init_done),
        .not_empty (not_empty),
        .newest    (newest),
        .oldest    (oldest),
        .valid_tag (valid_tag),
        .not_full  (not_full),
        .out_valid (out_valid)
    );

    rob_ready_scan u_ready_scan
    (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_idx    (wr.idx),
        .oldest    (oldest),
        .valid_tag (valid_tag),
        .deq_en    (deq_en),
        .not_empty (not_empty),
        .init_done (init_done)
    );

    // ====================
    // Payload
    // ====================

    // Response data lands at the index the responder carries
    rob_ram #(.DEPTH(ROB_ENTRIES), .WIDTH(ROB_DATA_BITS), .OUT_STAGES(1)) u_data_ram
    (
        .clk   (clk),
        .waddr (wr.idx),
        .wen   (wr_en),
        .wdata (wr.data),
        .raddr (oldest),
        .rdata (rd_data)
    );

    // Meta is captured at allocation into the newest slot
    rob_ram #(.DEPTH(ROB_ENTRIES), .WIDTH(ROB_META_BITS), .OUT_STAGES(1)) u_meta_ram
    (
        .clk   (clk),
        .waddr (newest),
        .wen   (alloc_en),
        .wdata (alloc_meta),
        .raddr (oldest),
        .rdata (rd_meta)
    );

    // Both RAMs share the read address and latency, so the halves stay paired
    assign out = '{data: rd_data, meta: rd_meta};

endmodule

//--- tb_rob_top.sv
// Self-checking testbench for rob_top that runs a table of write-order scenarios and scoreboards the output
`timescale 1ns/1ns

module tb_rob_top;

    import rob_pkg::*;

    // Write-order modes used in the scenario table
    localparam int MODE_IN_ORDER = 0;
    localparam int MODE_REVERSE  = 1;
    localparam int MODE_RANDOM   = 2;
    localparam int NUM_ROWS      = 4;
    localparam int MAX_ITEMS     = 64;

    logic      clk;
    logic      reset;
    logic      alloc_en;
    rob_meta_t alloc_meta;
    rob_idx_t  alloc_idx;
    logic      not_full;
    logic      wr_en;
    rob_wr_t   wr;
    logic      deq_en;
    logic      not_empty;
    logic      out_valid;
    rob_out_t  out_word;

    // ====================
    // Scenario table
    // ====================

    // Each row holds a test name, item count, write order, hold flag and data base
    string     row_name  [0:NUM_ROWS-1];
    int        row_items [0:NUM_ROWS-1];
    int        row_mode  [0:NUM_ROWS-1];
    bit        row_hold  [0:NUM_ROWS-1];
    rob_data_t row_base  [0:NUM_ROWS-1];

    // Per-row scoreboard state indexed by item number
    int        order     [0:MAX_ITEMS-1];
    rob_idx_t  item_idx  [0:MAX_ITEMS-1];
    bit        written   [0:MAX_ITEMS-1];

    // Strobe totals since reset model the DUT ring pointers
    int        alloc_total;
    int        deq_total;
    string     cur_name;
    int        check_cnt;
    int        err_cnt;
    int        test_err_start;
    int        tests_passed;
    int        tests_failed;
    int        cycle_cnt;
    int        cycle_limit;
    integer    seed;

    rob_top u_dut
    (
        .clk        (clk),
        .reset      (reset),
        .alloc_en   (alloc_en),
        .alloc_meta (alloc_meta),
        .alloc_idx  (alloc_idx),
        .not_full   (not_full),
        .wr_en      (wr_en),
        .wr         (wr),
        .deq_en     (deq_en),
        .not_empty  (not_empty),
        .out_valid  (out_valid),
        .out        (out_word)
    );

    // 8 ns clock period
    always #4 clk = ~clk;

    // Run limit scales with the total number of items in the table
    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    // Fill one row of the scenario table
    task automatic set_row(input int r, input string name, input int items, input int mode,
                           input bit hold, input rob_data_t base);
        row_name[r]  = name;
        row_items[r] = items;
        row_mode[r]  = mode;
        row_hold[r]  = hold;
        row_base[r]  = base;
    endtask

    task automatic load_table();
        set_row(0, "in_order",       12, MODE_IN_ORDER, 1'b0, 32'hA000_0000);
        set_row(1, "reverse_groups", 16, MODE_REVERSE,  1'b0, 32'hB000_0000);
        set_row(2, "wrap_random",    40, MODE_RANDOM,   1'b0, 32'hC000_0000);
        set_row(3, "full_limit",     16, MODE_IN_ORDER, 1'b1, 32'hD000_0000);
    endtask

    // Compare one value against the model and log any mismatch
    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_cnt = check_cnt + 1;
        if (expected !== actual)
        begin
            err_cnt = err_cnt + 1;
            $display("[FAIL] %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        cur_name       = name;
        test_err_start = err_cnt;
    endtask

    task automatic finish_test();
        if (err_cnt == test_err_start)
        begin
            tests_passed = tests_passed + 1;
            $display("PASS   %s", cur_name);
        end
        else
        begin
            tests_failed = tests_failed + 1;
            $display("[FAIL] %s: %0d errors", cur_name, err_cnt - test_err_start);
        end
    endtask

    // Builds the write order of a row as a permutation of item numbers in windows of 8
    task automatic build_order(input int r);
        int n;
        int g;
        int hi;
        int j;
        int k;
        int tmp;
        n = row_items[r];
        for (j = 0; j < n; j++)
        begin
            order[j] = j;
        end
        for (g = 0; g < n; g += 8)
        begin
            hi = (g + 8 < n) ? g + 8 : n;
            if (row_mode[r] == MODE_REVERSE)
            begin
                for (j = g; j < hi; j++)
                begin
                    order[j] = hi - 1 - (j - g);
                end
            end
            else if (row_mode[r] == MODE_RANDOM)
            begin
                // Shuffle the window in place
                for (j = hi - 1; j > g; j--)
                begin
                    k        = g + ($unsigned($random(seed)) % (j - g + 1));
                    tmp      = order[j];
                    order[j] = order[k];
                    order[k] = tmp;
                end
            end
        end
    endtask

    // ====================
    // Row runner
    // ====================

    task automatic run_row(input int r);
        int   n;
        int   alloc_cnt;
        int   wr_cnt;
        int   out_cnt;
        int   item;
        bit   hold;
        bit   done;
        bit   do_alloc;
        bit   do_wr;
        bit   do_deq;
        start_test(row_name[r]);
        build_order(r);
        n         = row_items[r];
        hold      = row_hold[r];
        alloc_cnt = 0;
        wr_cnt    = 0;
        out_cnt   = 0;
        done      = 1'b0;
        do_alloc  = 1'b0;
        do_wr     = 1'b0;
        do_deq    = 1'b0;
        for (int i = 0; i < n; i++)
        begin
            written[i] = 1'b0;
        end
        while (!done)
        begin
            @(posedge clk);
            #1;
            // Strobes driven last cycle were sampled at this edge
            if (do_alloc)
                alloc_total = alloc_total + 1;
            if (do_deq)
                deq_total = deq_total + 1;

            if (out_valid)
            begin
                if (out_cnt >= n)
                begin
                    err_cnt = err_cnt + 1;
                    $display("Error in %s: out_valid with no dequeue outstanding", cur_name);
                end
                else
                begin
                    check_value("written before output", 1, written[out_cnt]);
                    check_value("out data", row_base[r] + out_cnt, out_word.data);
                    check_value("out meta", rob_meta_t'(out_cnt + r), out_word.meta);
                    out_cnt = out_cnt + 1;
                end
            end

            // Allocation stays open while fewer than ENTRIES minus MIN_FREE slots are outstanding
            check_value("not_full",
                        (alloc_total - deq_total) < (ROB_ENTRIES - ROB_MIN_FREE),
                        not_full);

            // In the full test the writes wait until allocation has stalled
            if (hold && (!not_full || alloc_cnt == n))
            begin
                check_value("allocs before full", ROB_ENTRIES - ROB_MIN_FREE, alloc_cnt);
                hold = 1'b0;
            end

            if (out_cnt == n)
            begin
                do_alloc = 1'b0;
                do_wr    = 1'b0;
                do_deq   = 1'b0;
                done     = 1'b1;
            end
            else
            begin
                // Only slots handed out in earlier cycles take a response
                do_wr = !hold && wr_cnt < n && order[wr_cnt] < alloc_cnt;
                if (do_wr)
                begin
                    item          = order[wr_cnt];
                    wr.idx        = item_idx[item];
                    wr.data       = row_base[r] + item;
                    written[item] = 1'b1;
                    wr_cnt        = wr_cnt + 1;
                end
                do_alloc = alloc_cnt < n && not_full;
                if (do_alloc)
                begin
                    check_value("alloc_idx", rob_idx_t'(alloc_total), alloc_idx);
                    item_idx[alloc_cnt] = alloc_idx;
                    alloc_meta          = rob_meta_t'(alloc_cnt + r);
                    alloc_cnt           = alloc_cnt + 1;
                end
                do_deq = not_empty;
            end
            alloc_en = do_alloc;
            wr_en    = do_wr;
            deq_en   = do_deq;
        end
        finish_test();
    endtask

    // ====================
    // Main sequence
    // ====================

    initial
    begin
        int total;
        clk          = 1'b0;
        reset        = 1'b1;
        alloc_en     = 1'b0;
        alloc_meta   = '0;
        wr_en        = 1'b0;
        wr           = '0;
        deq_en       = 1'b0;
        alloc_total  = 0;
        deq_total    = 0;
        check_cnt    = 0;
        err_cnt      = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_cnt    = 0;
        seed         = 6526;
        load_table();
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            total = total + row_items[r];
        end
        cycle_limit = 200 + 12 * total;

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // The valid RAM is still clearing, so nothing may be offered yet
        start_test("reset_state");
        check_value("not_full", 0, not_full);
        check_value("not_empty", 0, not_empty);
        check_value("out_valid", 0, out_valid);
        while (!not_full)
        begin
            @(posedge clk);
            #1;
            check_value("not_empty", 0, not_empty);
            check_value("out_valid", 0, out_valid);
        end
        check_value("first alloc_idx", 0, alloc_idx);
        finish_test();

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            run_row(r);
        end

        $display("Tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 tests_passed, tests_failed, check_cnt, err_cnt);
        if (err_cnt == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- tb.f
rob_pkg.sv
rob_ram.sv
rob_ram_init.sv
rob_ready_scan.sv
rob_ptr_ctrl.sv
rob_top.sv
tb_rob_top.sv
